//--- Makefile
TOP = addrgen_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/10ps \
		--top-module $(TOP) -f addrgen_top.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- addrgen_top.f
source/addrgen_pkg.sv
source/addrgen_cmd_ctrl.sv
source/addrgen_burst_split.sv
source/addrgen_lsu_queue.sv
source/addrgen_top.sv
test/addrgen_asserts.sv
test/addrgen_tb.sv

//--- source/addrgen_burst_split.sv
/*
  Burst splitter of the address generator
  - Unit-stride jobs become INCR bursts bounded by 256 beats and 4 KiB pages
  - Strided jobs become one single-beat transaction per element
  - Drives AR for loads, AW for stores, and pushes every transaction to the queue
  - Keeps loads and stores from mixing in the queue
*/

`timescale 1ns/10ps

module addrgen_burst_split (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Job from the controller
  input  logic                                job_valid_i,
  output logic                                job_ready_o,
  output logic                                job_done_o,
  input  logic [addrgen_pkg::ADDR_W-1:0]      job_addr_i,
  input  logic [addrgen_pkg::LEN_W-1:0]       job_len_i,
  input  addrgen_pkg::vew_e                   job_vew_i,
  input  logic [addrgen_pkg::STRIDE_W-1:0]    job_stride_i,
  input  logic                                job_is_load_i,
  input  logic                                job_is_burst_i,
  // AR channel
  output logic [addrgen_pkg::ADDR_W-1:0]      ar_addr_o,
  output logic [7:0]                          ar_len_o,
  output logic [2:0]                          ar_size_o,
  output logic                                ar_valid_o,
  input  logic                                ar_ready_i,
  // AW channel
  output logic [addrgen_pkg::ADDR_W-1:0]      aw_addr_o,
  output logic [7:0]                          aw_len_o,
  output logic [2:0]                          aw_size_o,
  output logic                                aw_valid_o,
  input  logic                                aw_ready_i,
  // Queue toward the load/store units
  input  logic                                q_full_i,
  input  logic                                q_empty_i,
  input  logic                                q_head_is_load_i,
  output logic                                q_push_o,
  output logic [addrgen_pkg::ADDR_W-1:0]      q_addr_o,
  output logic [7:0]                          q_len_o,
  output logic [2:0]                          q_size_o,
  output logic                                q_is_load_o
);

  localparam int unsigned AW = addrgen_pkg::ADDR_W;

  addrgen_pkg::split_state_e state_q, state_d;

  // Current job
  logic                             is_load_q;
  logic                             is_burst_q;
  addrgen_pkg::vew_e                vew_q;
  logic [addrgen_pkg::STRIDE_W-1:0] stride_q;
  logic [AW-1:0]                    cur_addr_q, cur_addr_d;
  logic [addrgen_pkg::LEN_W-1:0]    rem_q, rem_d;

  // Bounds of the current burst
  logic [AW-1:0] start_q, end_q, next_q;
  logic [AW-1:0] bnd_start, bnd_end, data_end, cap_end, page_end;

  logic [AW-1:0] burst_span, covered;
  logic [7:0]    ax_len;
  logic [2:0]    ax_size;
  logic          order_ok, issue, ax_ready, ax_fire;

  //////////////////////////////
  // Burst bounds
  //////////////////////////////

  // Bounds follow the address and count of the next cycle
  always_comb begin
    bnd_start = {cur_addr_d[AW-1:addrgen_pkg::BUS_SIZE_LOG],
                 {addrgen_pkg::BUS_SIZE_LOG{1'b0}}};
    // Last data byte, rounded up to the end of its bus word
    data_end  = (cur_addr_d + (AW'(rem_d) << vew_q) - 1'b1) |
                AW'(addrgen_pkg::BUS_BYTES - 1);
    cap_end   = bnd_start + AW'(addrgen_pkg::MAX_BEATS * addrgen_pkg::BUS_BYTES - 1);
    page_end  = {bnd_start[AW-1:addrgen_pkg::PAGE_BITS], {addrgen_pkg::PAGE_BITS{1'b1}}};
    bnd_end   = data_end;
    if (cap_end < bnd_end) begin
      bnd_end = cap_end;
    end
    if (page_end < bnd_end) begin
      bnd_end = page_end;
    end
  end

  always_ff @(posedge clk_i) begin
    start_q <= bnd_start;
    end_q   <= bnd_end;
    next_q  <= bnd_end + 1'b1;
  end

  //////////////////////////////
  // Transaction fields
  //////////////////////////////

  assign burst_span = end_q - start_q;
  assign covered    = (end_q - cur_addr_q + 1'b1) >> vew_q;
  assign ax_len     = is_burst_q ? burst_span[addrgen_pkg::BUS_SIZE_LOG +: 8] : 8'd0;
  assign ax_size    = is_burst_q ? 3'(addrgen_pkg::BUS_SIZE_LOG) : {1'b0, vew_q};

  // No AR and AW mix while the queue holds the other direction
  assign order_ok = q_empty_i || (q_head_is_load_i == is_load_q);
  assign issue    = (state_q == addrgen_pkg::SPLIT_ISSUE) && !q_full_i && order_ok;
  assign ax_ready = is_load_q ? ar_ready_i : aw_ready_i;
  assign ax_fire  = issue && ax_ready;

  assign ar_valid_o = issue && is_load_q;
  assign ar_addr_o  = cur_addr_q;
  assign ar_len_o   = ax_len;
  assign ar_size_o  = ax_size;
  assign aw_valid_o = issue && !is_load_q;
  assign aw_addr_o  = cur_addr_q;
  assign aw_len_o   = ax_len;
  assign aw_size_o  = ax_size;

  assign q_push_o    = ax_fire;
  assign q_addr_o    = cur_addr_q;
  assign q_len_o     = ax_len;
  assign q_size_o    = ax_size;
  assign q_is_load_o = is_load_q;

  //////////////////////////////
  // FSM
  //////////////////////////////

  assign job_ready_o = (state_q == addrgen_pkg::SPLIT_IDLE);

  always_comb begin
    state_d    = state_q;
    cur_addr_d = cur_addr_q;
    rem_d      = rem_q;
    job_done_o = 1'b0;
    case (state_q)
      addrgen_pkg::SPLIT_IDLE: begin
        if (job_valid_i) begin
          cur_addr_d = job_addr_i;
          rem_d      = job_len_i;
          state_d    = addrgen_pkg::SPLIT_SETUP;
        end
      end
      addrgen_pkg::SPLIT_SETUP: state_d = addrgen_pkg::SPLIT_ISSUE;
      addrgen_pkg::SPLIT_ISSUE: begin
        if (ax_fire) begin
          if (is_burst_q) begin
            cur_addr_d = next_q;
            // Count stops at zero
            rem_d = (AW'(rem_q) > covered) ? rem_q - covered[addrgen_pkg::LEN_W-1:0] : '0;
          end else begin
            cur_addr_d = cur_addr_q + stride_q;
            rem_d      = rem_q - 1'b1;
          end
          if (rem_d == '0) begin
            job_done_o = 1'b1;
            state_d    = addrgen_pkg::SPLIT_IDLE;
          end
        end
      end
      default: state_d = addrgen_pkg::SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    cur_addr_q <= cur_addr_d;
    rem_q      <= rem_d;
    if (job_valid_i && job_ready_o) begin
      is_load_q  <= job_is_load_i;
      is_burst_q <= job_is_burst_i;
      vew_q      <= job_vew_i;
      stride_q   <= job_stride_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= addrgen_pkg::SPLIT_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

//--- source/addrgen_cmd_ctrl.sv
/*
  Command controller of the address generator
  - Takes one vector load/store command at a time
  - Checks the base address against the element width
  - Hands the job to the burst splitter and acknowledges completion
*/

`timescale 1ns/10ps

module addrgen_cmd_ctrl (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Command port
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  addrgen_pkg::mem_op_e                req_op_i,
  input  logic [addrgen_pkg::ADDR_W-1:0]      req_addr_i,
  input  logic [addrgen_pkg::LEN_W-1:0]       req_len_i,
  input  addrgen_pkg::vew_e                   req_vew_i,
  input  logic [addrgen_pkg::STRIDE_W-1:0]    req_stride_i,
  output logic                                ack_o,
  output logic                                error_o,
  // Job toward the splitter
  output logic                                job_valid_o,
  input  logic                                job_ready_i,
  input  logic                                job_done_i,
  output logic [addrgen_pkg::ADDR_W-1:0]      job_addr_o,
  output logic [addrgen_pkg::LEN_W-1:0]       job_len_o,
  output addrgen_pkg::vew_e                   job_vew_o,
  output logic [addrgen_pkg::STRIDE_W-1:0]    job_stride_o,
  output logic                                job_is_load_o,
  output logic                                job_is_burst_o
);

  addrgen_pkg::ctrl_state_e state_q, state_d;
  logic job_pend_q, job_pend_d;
  logic misaligned;
  logic [addrgen_pkg::ADDR_W-1:0] elem_mask;

  // Registered command
  logic [addrgen_pkg::ADDR_W-1:0]   addr_q;
  logic [addrgen_pkg::LEN_W-1:0]    len_q;
  addrgen_pkg::vew_e                vew_q;
  logic [addrgen_pkg::STRIDE_W-1:0] stride_q;
  logic                             is_load_q;
  logic                             is_burst_q;

  assign req_ready_o = (state_q == addrgen_pkg::CTRL_IDLE);

  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      addr_q     <= req_addr_i;
      len_q      <= req_len_i;
      vew_q      <= req_vew_i;
      stride_q   <= req_stride_i;
      is_load_q  <= (req_op_i inside {addrgen_pkg::OP_VLE, addrgen_pkg::OP_VLSE});
      // Unit-stride ops become INCR bursts
      is_burst_q <= (req_op_i inside {addrgen_pkg::OP_VLE, addrgen_pkg::OP_VSE});
    end
  end

  // Base must be a multiple of the element bytes
  assign elem_mask  = (addrgen_pkg::ADDR_W'(1) << vew_q) - 1'b1;
  assign misaligned = |(addr_q & elem_mask);

  always_comb begin
    state_d    = state_q;
    job_pend_d = job_pend_q;
    ack_o      = 1'b0;
    error_o    = 1'b0;
    case (state_q)
      addrgen_pkg::CTRL_IDLE: begin
        if (req_valid_i) begin
          state_d = addrgen_pkg::CTRL_CHECK;
        end
      end
      addrgen_pkg::CTRL_CHECK: begin
        if (misaligned) begin
          ack_o   = 1'b1;
          error_o = 1'b1;
          state_d = addrgen_pkg::CTRL_IDLE;
        end else begin
          job_pend_d = 1'b1;
          state_d    = addrgen_pkg::CTRL_BUSY;
        end
      end
      addrgen_pkg::CTRL_BUSY: begin
        if (job_valid_o && job_ready_i) begin
          job_pend_d = 1'b0;
        end
        // Splitter reports its last AR/AW transaction
        if (job_done_i) begin
          ack_o   = 1'b1;
          state_d = addrgen_pkg::CTRL_IDLE;
        end
      end
      default: state_d = addrgen_pkg::CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= addrgen_pkg::CTRL_IDLE;
      job_pend_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      job_pend_q <= job_pend_d;
    end
  end

  assign job_valid_o    = (state_q == addrgen_pkg::CTRL_BUSY) && job_pend_q;
  assign job_addr_o     = addr_q;
  assign job_len_o      = len_q;
  assign job_vew_o      = vew_q;
  assign job_stride_o   = stride_q;
  assign job_is_load_o  = is_load_q;
  assign job_is_burst_o = is_burst_q;

endmodule

//--- source/addrgen_lsu_queue.sv
/*
  Request queue toward the load/store units
  - Circular buffer with read and write pointers and an entry count
  - Holds address, len, size and direction of every issued transaction
*/

`timescale 1ns/10ps

module addrgen_lsu_queue (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             push_i,
  input  logic [addrgen_pkg::ADDR_W-1:0]   push_addr_i,
  input  logic [7:0]                       push_len_i,
  input  logic [2:0]                       push_size_i,
  input  logic                             push_is_load_i,
  output logic                             full_o,
  output logic                             empty_o,
  output logic                             head_is_load_o,
  output logic                             lsu_valid_o,
  input  logic                             lsu_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0]   lsu_addr_o,
  output logic [7:0]                       lsu_len_o,
  output logic [2:0]                       lsu_size_o,
  output logic                             lsu_is_load_o
);

  localparam int unsigned DEPTH = addrgen_pkg::QUEUE_DEPTH;
  localparam int unsigned PTR_W = $clog2(DEPTH);

  logic [addrgen_pkg::ADDR_W-1:0] addr_mem [DEPTH];
  logic [7:0]                     len_mem  [DEPTH];
  logic [2:0]                     size_mem [DEPTH];
  logic                           load_mem [DEPTH];

  logic [PTR_W-1:0] wptr_q, rptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push, do_pop;

  assign full_o      = (count_q == (PTR_W+1)'(DEPTH));
  assign empty_o     = (count_q == '0);
  assign lsu_valid_o = !empty_o;

  assign do_push = push_i && !full_o;
  assign do_pop  = lsu_valid_o && lsu_ready_i;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      addr_mem[wptr_q] <= push_addr_i;
      len_mem[wptr_q]  <= push_len_i;
      size_mem[wptr_q] <= push_size_i;
      load_mem[wptr_q] <= push_is_load_i;
    end
  end

  // Pointers wrap naturally at DEPTH
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      count_q <= '0;
    end else begin
      if (do_push) begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (do_pop) begin
        rptr_q <= rptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (!do_push && do_pop) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  assign lsu_addr_o     = addr_mem[rptr_q];
  assign lsu_len_o      = len_mem[rptr_q];
  assign lsu_size_o     = size_mem[rptr_q];
  assign lsu_is_load_o  = load_mem[rptr_q];
  assign head_is_load_o = load_mem[rptr_q];

endmodule

//--- source/addrgen_pkg.sv
/*
  Shared definitions of the vector address generator
  - Address, length and stride widths
  - Bus, page, burst and queue limits
  - Opcode, element width and FSM state encodings
*/

package addrgen_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned LEN_W    = 16;
  localparam int unsigned STRIDE_W = 32;

  //////////////////////////////
  // Bus and burst limits
  //////////////////////////////

  // 64-bit data bus
  localparam int unsigned BUS_BYTES    = 8;
  localparam int unsigned BUS_SIZE_LOG = 3;

  // 4 KiB pages, AXI INCR bursts of at most 256 beats
  localparam int unsigned PAGE_BITS = 12;
  localparam int unsigned MAX_BEATS = 256;

  // Entries in the queue toward the load/store units
  localparam int unsigned QUEUE_DEPTH = 4;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  typedef enum logic [1:0] {
    OP_VLE  = 2'd0,
    OP_VSE  = 2'd1,
    OP_VLSE = 2'd2,
    OP_VSSE = 2'd3
  } mem_op_e;

  // Value is log2 of the element bytes
  typedef enum logic [1:0] {
    EW8  = 2'd0,
    EW16 = 2'd1,
    EW32 = 2'd2,
    EW64 = 2'd3
  } vew_e;

  typedef enum logic [1:0] {
    CTRL_IDLE  = 2'd0,
    CTRL_CHECK = 2'd1,
    CTRL_BUSY  = 2'd2
  } ctrl_state_e;

  typedef enum logic [1:0] {
    SPLIT_IDLE  = 2'd0,
    SPLIT_SETUP = 2'd1,
    SPLIT_ISSUE = 2'd2
  } split_state_e;

endpackage

//--- source/addrgen_top.sv
/*
  Vector memory address generator, top level
  - Command controller, burst splitter and load/store request queue
*/

`timescale 1ns/10ps

module addrgen_top (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  // Command port
  input  logic                                req_valid_i,
  output logic                                req_ready_o,
  input  addrgen_pkg::mem_op_e                req_op_i,
  input  logic [addrgen_pkg::ADDR_W-1:0]      req_addr_i,
  input  logic [addrgen_pkg::LEN_W-1:0]       req_len_i,
  input  addrgen_pkg::vew_e                   req_vew_i,
  input  logic [addrgen_pkg::STRIDE_W-1:0]    req_stride_i,
  output logic                                ack_o,
  output logic                                error_o,
  // AR channel
  output logic [addrgen_pkg::ADDR_W-1:0]      ar_addr_o,
  output logic [7:0]                          ar_len_o,
  output logic [2:0]                          ar_size_o,
  output logic                                ar_valid_o,
  input  logic                                ar_ready_i,
  // AW channel
  output logic [addrgen_pkg::ADDR_W-1:0]      aw_addr_o,
  output logic [7:0]                          aw_len_o,
  output logic [2:0]                          aw_size_o,
  output logic                                aw_valid_o,
  input  logic                                aw_ready_i,
  // Load/store unit port
  output logic                                lsu_valid_o,
  input  logic                                lsu_ready_i,
  output logic [addrgen_pkg::ADDR_W-1:0]      lsu_addr_o,
  output logic [7:0]                          lsu_len_o,
  output logic [2:0]                          lsu_size_o,
  output logic                                lsu_is_load_o
);

  // Controller to splitter
  logic                             job_valid, job_ready, job_done;
  logic [addrgen_pkg::ADDR_W-1:0]   job_addr;
  logic [addrgen_pkg::LEN_W-1:0]    job_len;
  addrgen_pkg::vew_e                job_vew;
  logic [addrgen_pkg::STRIDE_W-1:0] job_stride;
  logic                             job_is_load, job_is_burst;

  // Splitter to queue
  logic                           push, push_is_load;
  logic [addrgen_pkg::ADDR_W-1:0] push_addr;
  logic [7:0]                     push_len;
  logic [2:0]                     push_size;
  logic                           q_full, q_empty, q_head_is_load;

  addrgen_cmd_ctrl u_cmd_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_op_i      (req_op_i),
    .req_addr_i    (req_addr_i),
    .req_len_i     (req_len_i),
    .req_vew_i     (req_vew_i),
    .req_stride_i  (req_stride_i),
    .ack_o         (ack_o),
    .error_o       (error_o),
    .job_valid_o   (job_valid),
    .job_ready_i   (job_ready),
    .job_done_i    (job_done),
    .job_addr_o    (job_addr),
    .job_len_o     (job_len),
    .job_vew_o     (job_vew),
    .job_stride_o  (job_stride),
    .job_is_load_o (job_is_load),
    .job_is_burst_o(job_is_burst)
  );

  addrgen_burst_split u_burst_split (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .job_valid_i     (job_valid),
    .job_ready_o     (job_ready),
    .job_done_o      (job_done),
    .job_addr_i      (job_addr),
    .job_len_i       (job_len),
    .job_vew_i       (job_vew),
    .job_stride_i    (job_stride),
    .job_is_load_i   (job_is_load),
    .job_is_burst_i  (job_is_burst),
    .ar_addr_o       (ar_addr_o),
    .ar_len_o        (ar_len_o),
    .ar_size_o       (ar_size_o),
    .ar_valid_o      (ar_valid_o),
    .ar_ready_i      (ar_ready_i),
    .aw_addr_o       (aw_addr_o),
    .aw_len_o        (aw_len_o),
    .aw_size_o       (aw_size_o),
    .aw_valid_o      (aw_valid_o),
    .aw_ready_i      (aw_ready_i),
    .q_full_i        (q_full),
    .q_empty_i       (q_empty),
    .q_head_is_load_i(q_head_is_load),
    .q_push_o        (push),
    .q_addr_o        (push_addr),
    .q_len_o         (push_len),
    .q_size_o        (push_size),
    .q_is_load_o     (push_is_load)
  );

  addrgen_lsu_queue u_lsu_queue (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .push_i        (push),
    .push_addr_i   (push_addr),
    .push_len_i    (push_len),
    .push_size_i   (push_size),
    .push_is_load_i(push_is_load),
    .full_o        (q_full),
    .empty_o       (q_empty),
    .head_is_load_o(q_head_is_load),
    .lsu_valid_o   (lsu_valid_o),
    .lsu_ready_i   (lsu_ready_i),
    .lsu_addr_o    (lsu_addr_o),
    .lsu_len_o     (lsu_len_o),
    .lsu_size_o    (lsu_size_o),
    .lsu_is_load_o (lsu_is_load_o)
  );

endmodule

//--- test/addrgen_asserts.sv
/*
  Concurrent checks on the address generator ports
  - AR and AW never valid in the same cycle
  - AR/AW address stable while valid waits for ready
  - error only together with ack
*/

`timescale 1ns/10ps

module addrgen_asserts (
  input logic                           clk_i,
  input logic                           rst_ni,
  input logic                           ar_valid_i,
  input logic                           ar_ready_i,
  input logic [addrgen_pkg::ADDR_W-1:0] ar_addr_i,
  input logic                           aw_valid_i,
  input logic                           aw_ready_i,
  input logic [addrgen_pkg::ADDR_W-1:0] aw_addr_i,
  input logic                           ack_i,
  input logic                           error_i
);

  // One direction at a time
  assert property (@(posedge clk_i) disable iff (!rst_ni) !(ar_valid_i && aw_valid_i))
    else $error("AR and AW valid in the same cycle");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    ar_valid_i && !ar_ready_i |=> $stable(ar_addr_i))
    else $error("AR address changed while waiting for ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    aw_valid_i && !aw_ready_i |=> $stable(aw_addr_i))
    else $error("AW address changed while waiting for ready");

  assert property (@(posedge clk_i) disable iff (!rst_ni) error_i |-> ack_i)
    else $error("error raised without ack");

endmodule

bind addrgen_top addrgen_asserts u_asserts (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .ar_valid_i(ar_valid_o),
  .ar_ready_i(ar_ready_i),
  .ar_addr_i (ar_addr_o),
  .aw_valid_i(aw_valid_o),
  .aw_ready_i(aw_ready_i),
  .aw_addr_i (aw_addr_o),
  .ack_i     (ack_o),
  .error_i   (error_o)
);

//--- test/addrgen_tb.sv
/*
  Testbench of the vector address generator
  - Clock, reset and commands read from the test data file
  - Random AR/AW ready and LSU stall driving
  - Reference model of the expected AR/AW transactions
  - Monitors of the AXI channels, queue ordering and LSU port
*/

`timescale 1ns/10ps

module addrgen_tb;

  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
    logic [2:0]  size;
    logic        is_load;
  } xact_t;

  logic                             clk_i, rst_ni;
  logic                             req_valid_i, req_ready_o;
  addrgen_pkg::mem_op_e             req_op_i;
  logic [addrgen_pkg::ADDR_W-1:0]   req_addr_i;
  logic [addrgen_pkg::LEN_W-1:0]    req_len_i;
  addrgen_pkg::vew_e                req_vew_i;
  logic [addrgen_pkg::STRIDE_W-1:0] req_stride_i;
  logic                             ack_o, error_o;
  logic [31:0]                      ar_addr_o, aw_addr_o, lsu_addr_o;
  logic [7:0]                       ar_len_o, aw_len_o, lsu_len_o;
  logic [2:0]                       ar_size_o, aw_size_o, lsu_size_o;
  logic                             ar_valid_o, ar_ready_i, aw_valid_o, aw_ready_i;
  logic                             lsu_valid_o, lsu_ready_i, lsu_is_load_o;

  xact_t           exp_q[$];     // Expected AR/AW transactions in issue order
  xact_t           issued_q[$];  // Model records still held by the DUT queue
  integer          seed       = 32'h9000;
  int              err_count  = 0;
  int              stall_left = 0;
  int              n_tests    = 0;
  int              n_bad      = 0;
  logic [8*24-1:0] cur_name;

  addrgen_top UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////
  // Checks and reference model
  //////////////////////////////

  function automatic void check_value(string what, logic [31:0] exp, logic [31:0] act);
    assert (exp == act) else begin
      $display("FAILED %0s: %0s expected %0h actual %0h", cur_name, what, exp, act);
      err_count++;
    end
  endfunction

  // Fields shown as addr/len/size/load
  function automatic void compare_xact(string what, xact_t exp, xact_t act);
    assert (exp == act) else begin
      $display("FAILED %0s: %0s expected %h/%0d/%0d/%0b actual %h/%0d/%0d/%0b", cur_name,
               what, exp.addr, exp.len, exp.size, exp.is_load,
               act.addr, act.len, act.size, act.is_load);
      err_count++;
    end
  endfunction

  function automatic void build_expected(addrgen_pkg::mem_op_e op, logic [31:0] addr,
                                         logic [31:0] len, int vew, logic [31:0] stride);
    logic [31:0] cur, rem, start, stop, limit, beats, covered;
    logic        is_load;
    xact_t       x;
    is_load = (op == addrgen_pkg::OP_VLE) || (op == addrgen_pkg::OP_VLSE);
    // Misaligned base gives no transaction at all
    if ((addr & ((32'd1 << vew) - 32'd1)) != 0) begin
      return;
    end
    if (op == addrgen_pkg::OP_VLE || op == addrgen_pkg::OP_VSE) begin
      cur = addr;
      rem = len;
      while (rem != 0) begin
        start = cur & ~32'h7;
        stop  = (cur + (rem << vew) - 32'd1) | 32'h7;
        // 256 beats of 8 bytes, then the 4 KiB page end
        limit = start + 32'd2047;
        if (limit < stop) begin
          stop = limit;
        end
        limit = start | 32'hFFF;
        if (limit < stop) begin
          stop = limit;
        end
        beats = (stop - start) / 8 + 1;
        x = {cur, 8'(beats - 1), 3'd3, is_load};
        exp_q.push_back(x);
        covered = (stop - cur + 1) >> vew;
        rem = (rem > covered) ? rem - covered : 32'd0;
        cur = stop + 1;
      end
    end else begin
      for (int k = 0; k < len; k++) begin
        x = {addr + k * stride, 8'd0, 3'(vew), is_load};
        exp_q.push_back(x);
      end
    end
  endfunction

  //////////////////////////////
  // Ready driving
  //////////////////////////////

  initial begin
    ar_ready_i  = 1'b0;
    aw_ready_i  = 1'b0;
    lsu_ready_i = 1'b1;
    forever begin
      @(negedge clk_i);
      ar_ready_i  = ($random(seed) & 3) != 0;
      aw_ready_i  = ($random(seed) & 3) != 0;
      lsu_ready_i = (stall_left == 0);
      if (stall_left > 0) begin
        stall_left--;
      end
    end
  end

  //////////////////////////////
  // Monitors
  //////////////////////////////

  always @(posedge clk_i) begin
    xact_t obs;
    xact_t ref_x;
    xact_t pushed_x;
    logic  has_load;
    logic  has_store;
    logic  fire;
    if (rst_ni) begin
      has_load  = 1'b0;
      has_store = 1'b0;
      foreach (issued_q[i]) begin
        if (issued_q[i].is_load) begin
          has_load = 1'b1;
        end else begin
          has_store = 1'b1;
        end
      end
      check_value("lsu_valid_o", issued_q.size() != 0, lsu_valid_o);
      assert (!(aw_valid_o && has_load)) else begin
        $display("%0s: AW valid while load entries wait in the queue", cur_name);
        err_count++;
      end
      assert (!(ar_valid_o && has_store)) else begin
        $display("%0s: AR valid while store entries wait in the queue", cur_name);
        err_count++;
      end
      fire = (ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i);
      if (ar_valid_o) begin
        obs = {ar_addr_o, ar_len_o, ar_size_o, 1'b1};
      end else begin
        obs = {aw_addr_o, aw_len_o, aw_size_o, 1'b0};
      end
      // An unexpected transaction still takes a queue slot
      pushed_x = obs;
      if (fire) begin
        assert (issued_q.size() < addrgen_pkg::QUEUE_DEPTH) else begin
          $display("%0s: transaction issued while the queue is full", cur_name);
          err_count++;
        end
        assert (exp_q.size() != 0) else begin
          $display("%0s: unexpected transaction at address %h", cur_name, obs.addr);
          err_count++;
        end
        if (exp_q.size() != 0) begin
          pushed_x = exp_q.pop_front();
          compare_xact("AR/AW", pushed_x, obs);
        end
      end
      // Pop before push keeps the FIFO order of this edge
      if (lsu_valid_o && lsu_ready_i && issued_q.size() != 0) begin
        ref_x = issued_q.pop_front();
        compare_xact("LSU", ref_x, {lsu_addr_o, lsu_len_o, lsu_size_o, lsu_is_load_o});
      end
      if (fire) begin
        issued_q.push_back(pushed_x);
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  task automatic run_test(input logic [8*24-1:0] name, input int op, input logic [31:0] addr,
                          input int len, input int vew, input logic [31:0] stride,
                          input int stall, input int exp_err, output logic hung);
    int   errs_before;
    int   cycles;
    logic taken;
    logic got_ack;
    logic got_err;
    errs_before = err_count;
    hung        = 1'b0;
    taken       = 1'b0;
    got_ack     = 1'b0;
    got_err     = 1'b0;
    cur_name    = name;
    build_expected(addrgen_pkg::mem_op_e'(op[1:0]), addr, len, vew, stride);
    req_valid_i  = 1'b1;
    req_op_i     = addrgen_pkg::mem_op_e'(op[1:0]);
    req_addr_i   = addr;
    req_len_i    = len[15:0];
    req_vew_i    = addrgen_pkg::vew_e'(vew[1:0]);
    req_stride_i = stride;
    cycles = 0;
    while (!taken && cycles < 100) begin
      @(posedge clk_i);
      taken = req_ready_o;
      cycles++;
    end
    if (taken) begin
      stall_left = stall;
    end
    @(negedge clk_i);
    req_valid_i = 1'b0;
    if (!taken) begin
      $display("%0s: command was not taken within 100 cycles", name);
      hung = 1'b1;
      err_count++;
    end else begin
      cycles = 0;
      while (!got_ack && cycles < 5000) begin
        @(posedge clk_i);
        got_ack = ack_o;
        got_err = error_o;
        cycles++;
      end
      @(negedge clk_i);
      if (!got_ack) begin
        $display("%0s: no ack within 5000 cycles", name);
        hung = 1'b1;
        err_count++;
      end else begin
        check_value("error flag", exp_err, got_err);
        check_value("transactions not issued", 0, exp_q.size());
      end
    end
    exp_q.delete();
    n_tests++;
    if (err_count == errs_before) begin
      $display("PASS    %0s", name);
    end else begin
      $display("FAIL    %0s (%0d errors)", name, err_count - errs_before);
      n_bad++;
    end
  endtask

  initial begin
    int              fd;
    int              n;
    int              cycles;
    int              op, len, vew, stall, exp_err;
    logic [31:0]     addr, stride;
    logic [8*24-1:0] name;
    logic            hung;
    string           line;
    rst_ni       = 1'b0;
    req_valid_i  = 1'b0;
    req_op_i     = addrgen_pkg::OP_VLE;
    req_addr_i   = '0;
    req_len_i    = '0;
    req_vew_i    = addrgen_pkg::EW8;
    req_stride_i = '0;
    hung         = 1'b0;
    cur_name     = "reset";
    repeat (2) @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("req_ready_o after reset", 1, req_ready_o);
    check_value("ack_o after reset", 0, ack_o);
    check_value("error_o after reset", 0, error_o);
    check_value("ar_valid_o after reset", 0, ar_valid_o);
    check_value("aw_valid_o after reset", 0, aw_valid_o);
    check_value("lsu_valid_o after reset", 0, lsu_valid_o);

    fd = $fopen("test/addrgen_tests.txt", "r");
    if (fd == 0) begin
      $display("cannot open the test data file");
      err_count++;
    end else begin
      while (!hung && $fgets(line, fd) > 0) begin
        if (line.len() < 2 || line.getc(0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %d %h %d %d %h %d %d", name, op, addr, len, vew, stride,
                    stall, exp_err);
        if (n != 8) begin
          $display("malformed line in the test data file");
          err_count++;
          continue;
        end
        run_test(name, op, addr, len, vew, stride, stall, exp_err, hung);
      end
      $fclose(fd);
    end

    // Let the LSU port empty the queue
    cur_name = "final drain";
    cycles   = 0;
    while (issued_q.size() != 0 && cycles < 500) begin
      @(posedge clk_i);
      cycles++;
    end
    @(negedge clk_i);
    if (issued_q.size() != 0) begin
      $display("LSU queue did not drain within 500 cycles");
      err_count++;
    end

    $display("Summary: %0d tests run, %0d with errors, %0d check errors",
             n_tests, n_bad, err_count);
    if (err_count == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

//--- test/addrgen_tests.txt
# name op(0 vle 1 vse 2 vlse 3 vsse) addr(hex) len vew(log2 bytes) stride(hex)
# lsu_stall(cycles of lsu_ready low from command accept) exp_err
vle_one_page       0 00001000 16  3 00000000 0  0
vle_unaligned_ew32 0 00002004 10  2 00000000 0  0
vse_page_cross     1 00003F00 400 3 00000000 0  0
vse_ew16_cross     1 00001FF0 100 1 00000000 0  0
vlse_ew32          2 00010000 6   2 00000100 0  0
vsse_ew64          3 00020008 5   3 00000018 0  0
vlse_ew8_odd       2 00030001 7   0 00000003 0  0
misaligned_vle     0 00001002 4   2 00000000 0  1
misaligned_vsse    3 00005004 4   3 00000008 0  1
stall_loads        2 00040000 8   3 00000040 30 0
store_after_loads  3 00050000 6   2 00000010 12 0
vle_cap_2k         0 00006000 600 2 00000000 0  0
stall_bursts       0 00007F80 700 3 00000000 20 0
vse_byte_unaligned 1 00008003 13  0 00000000 0  0
vlse_page_stride   2 0000F000 3   3 00001000 0  0
stall_stores       3 00009000 7   3 00000008 25 0
load_after_stores  2 0000A000 4   2 00000004 8  0
